// ==== adxl_pkg.sv ====
package adxl_pkg;

    localparam int NUM_WORDS  = 15;
    localparam int BYTE_LANES = 4;
    localparam int WORD_W     = 32;
    localparam int WORD_IDX_W = 4;

    localparam logic [6:0] DEV_ADDR = 7'h53;  // adxl345 with alt address pin low

    localparam logic [7:0] CMD_WRITE_REG = 8'h02;
    localparam logic [7:0] CMD_PTR       = 8'h01;
    localparam logic [7:0] PTR_START     = 8'h00;
    localparam logic [7:0] ADDR_LIMIT    = 8'h39;  // last swept reg, also read length

    // bit n set means byte lane n of that word is host writable
    localparam logic [NUM_WORDS-1:0][BYTE_LANES-1:0] WRITE_MASK = '{
        4'b0001,  // 0x38 fifo_ctl
        4'b0000,  // 0x34
        4'b0010,  // 0x30 data_format only
        4'b1111,  // 0x2c
        4'b0111,  // 0x28 act_tap_status is read only
        4'b1111,  // 0x24
        4'b1111,  // 0x20
        4'b1110,  // 0x1c reserved byte skipped
        4'b0000,  // 0x18
        4'b0000,  // 0x14
        4'b0000,  // 0x10
        4'b0000,  // 0x0c
        4'b0000,  // 0x08
        4'b0000,  // 0x04
        4'b0000   // 0x00
    };

    // register address, flat for counting or split for word/lane decode
    typedef union packed {
        logic [5:0] flat;
        struct packed {
            logic [WORD_IDX_W-1:0] word;
            logic [1:0]            lane;
        } split;
    } reg_addr_u;

endpackage

// ==== adxl_host_port.sv ====
`timescale 1ns/1ps

module adxl_host_port import adxl_pkg::*; (
    input  logic                            CLK,
    input  logic                            RESETN,
    input  logic                            host_wr,
    input  logic [WORD_IDX_W-1:0]           host_waddr,
    input  logic [WORD_W-1:0]               host_wdata,
    input  logic [BYTE_LANES-1:0]           host_wstrb,
    input  logic                            host_rd,
    input  logic [WORD_IDX_W-1:0]           host_raddr,
    input  logic [NUM_WORDS*WORD_W-1:0]     word_data,
    output logic [NUM_WORDS-1:0]            word_we,
    output logic [WORD_W-1:0]               wr_data,
    output logic [BYTE_LANES-1:0]           wr_strb,
    output logic [WORD_W-1:0]               host_rdata,
    output logic                            host_rvalid
);

    logic [WORD_W-1:0] rd_word;

    // unmapped word index reads back as zero
    always_comb begin
        if (host_raddr < NUM_WORDS)
            rd_word = word_data[host_raddr*WORD_W +: WORD_W];
        else
            rd_word = '0;
    end

    always_ff @(posedge CLK) begin
        if (!RESETN) begin
            word_we     <= '0;
            host_rvalid <= 1'b0;
        end else begin
            for (int w = 0; w < NUM_WORDS; w++)
                word_we[w] <= host_wr && (host_waddr == w);  // one-hot enable
            host_rvalid <= host_rd;                          // fixed one cycle return
        end
    end

    always_ff @(posedge CLK) begin
        if (host_wr) begin
            wr_data <= host_wdata;
            wr_strb <= host_wstrb;
        end
        if (host_rd)
            host_rdata <= rd_word;
    end

endmodule

// ==== adxl_reg_word.sv ====
`timescale 1ns/1ps

module adxl_reg_word import adxl_pkg::*; #(
    parameter int                    WORD_INDEX = 0,
    parameter logic [BYTE_LANES-1:0] LANE_MASK  = '0
) (
    input  logic                  CLK,
    input  logic                  RESETN,
    input  logic                  we,
    input  logic [WORD_W-1:0]     wr_data,
    input  logic [BYTE_LANES-1:0] wr_strb,
    input  reg_addr_u             seq_addr,
    input  logic                  cap_we,
    input  logic [7:0]            cap_data,
    input  logic                  dirty_clr,
    output logic [WORD_W-1:0]     data,
    output logic [BYTE_LANES-1:0] dirty
);

    logic hit;

    assign hit = (seq_addr.split.word == WORD_INDEX[WORD_IDX_W-1:0]);  // sequencer addresses us

    always_ff @(posedge CLK) begin
        if (!RESETN) begin
            data  <= '0;
            dirty <= '0;
        end else begin
            for (int l = 0; l < BYTE_LANES; l++) begin
                if (dirty_clr && hit && seq_addr.split.lane == l)
                    dirty[l] <= 1'b0;
                // a fresh host write re-marks the lane even if it was just sent
                if (we && wr_strb[l] && LANE_MASK[l]) begin
                    data[l*8 +: 8] <= wr_data[l*8 +: 8];
                    dirty[l]       <= 1'b1;
                end else if (!we && cap_we && hit && seq_addr.split.lane == l) begin
                    data[l*8 +: 8] <= cap_data;  // readback, any lane
                end
            end
        end
    end

endmodule

// ==== adxl_sequencer.sv ====
`timescale 1ns/1ps

module adxl_sequencer import adxl_pkg::*; (
    input  logic                            CLK,
    input  logic                            RESETN,
    input  logic                            enable,
    input  logic [31:0]                     req_interval,
    input  logic [NUM_WORDS*WORD_W-1:0]     word_data,
    input  logic [NUM_WORDS*BYTE_LANES-1:0] dirty,
    input  logic [7:0]                      s_tdata,
    input  logic                            s_tvalid,
    input  logic                            s_tlast,
    input  logic                            m_tready,
    output logic [7:0]                      m_tdata,
    output logic [7:0]                      m_tuser,
    output logic                            m_tlast,
    output logic                            m_tvalid,
    output reg_addr_u                       seq_addr,
    output logic                            cap_we,
    output logic [7:0]                      cap_data,
    output logic                            dirty_clr
);

    enum logic [2:0] {
        ST_IDLE,
        ST_CHECK,
        ST_WRITE,
        ST_NEXT,
        ST_PTR,
        ST_READ,
        ST_AWAIT
    } state;

    reg_addr_u   addr;
    logic [1:0]  byte_cnt;
    logic [31:0] timer;
    logic        fire;
    logic        start_read;
    logic [7:0]  cur_byte;
    logic        load;
    logic [7:0]  nxt_data;
    logic [7:0]  nxt_user;
    logic        nxt_last;

    assign fire       = m_tvalid && m_tready;
    assign start_read = enable && !(|dirty) && (timer >= req_interval);
    assign cur_byte   = word_data[addr.split.word*WORD_W + addr.split.lane*8 +: 8];

    assign seq_addr  = addr;
    assign cap_we    = (state == ST_AWAIT) && s_tvalid;
    assign cap_data  = s_tdata;
    assign dirty_clr = (state == ST_WRITE) && fire && m_tlast;  // frame fully accepted

    // next byte for the output register, loaded only when it is free
    always_comb begin
        load     = 1'b0;
        nxt_data = CMD_WRITE_REG;
        nxt_user = {DEV_ADDR, 1'b0};
        nxt_last = 1'b0;
        case (state)
            ST_IDLE: begin
                if (start_read) begin
                    load     = 1'b1;
                    nxt_data = CMD_PTR;
                end
            end
            ST_CHECK: begin
                load = dirty[addr.flat];
            end
            ST_WRITE: begin
                if (fire && !m_tlast) begin
                    load = 1'b1;
                    if (byte_cnt == 2'd0) begin
                        nxt_data = {2'b00, addr.flat};
                    end else begin
                        nxt_data = cur_byte;
                        nxt_last = 1'b1;
                    end
                end
            end
            ST_PTR: begin
                if (fire) begin
                    load     = 1'b1;
                    nxt_last = 1'b1;
                    if (m_tlast) begin
                        nxt_data = ADDR_LIMIT;         // read length
                        nxt_user = {DEV_ADDR, 1'b1};
                    end else begin
                        nxt_data = PTR_START;
                    end
                end
            end
            default: begin
                load = 1'b0;
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!RESETN) begin
            state     <= ST_IDLE;
            addr.flat <= '0;
            byte_cnt  <= '0;
            timer     <= '0;
            m_tvalid  <= 1'b0;
        end else begin
            if (load)
                m_tvalid <= 1'b1;
            else if (fire)
                m_tvalid <= 1'b0;

            case (state)
                ST_IDLE: begin
                    addr.flat <= '0;
                    if (timer < req_interval)
                        timer <= timer + 32'd1;
                    if (enable) begin
                        if (|dirty) begin
                            state <= ST_CHECK;
                        end else if (start_read) begin
                            state <= ST_PTR;
                            timer <= '0;
                        end
                    end
                end
                ST_CHECK: begin
                    byte_cnt <= '0;
                    if (dirty[addr.flat])
                        state <= ST_WRITE;
                    else
                        state <= ST_NEXT;
                end
                ST_WRITE: begin
                    if (fire) begin
                        if (m_tlast)
                            state <= ST_NEXT;
                        else
                            byte_cnt <= byte_cnt + 2'd1;
                    end
                end
                ST_NEXT: begin
                    if (addr.flat == ADDR_LIMIT[5:0]) begin
                        state <= ST_IDLE;
                    end else begin
                        addr.flat <= addr.flat + 6'd1;
                        state     <= ST_CHECK;
                    end
                end
                ST_PTR: begin
                    if (fire && m_tlast)
                        state <= ST_READ;  // read request already loaded
                end
                ST_READ: begin
                    if (fire)
                        state <= ST_AWAIT;
                end
                ST_AWAIT: begin
                    if (s_tvalid) begin
                        addr.flat <= addr.flat + 6'd1;
                        if (s_tlast)
                            state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // held steady while the sink stalls
    always_ff @(posedge CLK) begin
        if (load) begin
            m_tdata <= nxt_data;
            m_tuser <= nxt_user;
            m_tlast <= nxt_last;
        end
    end

endmodule

// ==== adxl_ctrl.sv ====
`timescale 1ns/1ps

module adxl_ctrl import adxl_pkg::*; (
    input  logic                  CLK,
    input  logic                  RESETN,
    input  logic                  host_wr,
    input  logic [WORD_IDX_W-1:0] host_waddr,
    input  logic [WORD_W-1:0]     host_wdata,
    input  logic [BYTE_LANES-1:0] host_wstrb,
    input  logic                  host_rd,
    input  logic [WORD_IDX_W-1:0] host_raddr,
    output logic [WORD_W-1:0]     host_rdata,
    output logic                  host_rvalid,
    input  logic                  enable,
    input  logic [31:0]           req_interval,
    output logic [7:0]            m_tdata,
    output logic [7:0]            m_tuser,
    output logic                  m_tlast,
    output logic                  m_tvalid,
    input  logic                  m_tready,
    input  logic [7:0]            s_tdata,
    input  logic                  s_tvalid,
    input  logic                  s_tlast,
    output logic                  s_tready
);

    logic [NUM_WORDS-1:0]            word_we;
    logic [WORD_W-1:0]               wr_data;
    logic [BYTE_LANES-1:0]           wr_strb;
    logic [NUM_WORDS*WORD_W-1:0]     word_data;
    logic [NUM_WORDS*BYTE_LANES-1:0] dirty;
    reg_addr_u                       seq_addr;
    logic                            cap_we;
    logic [7:0]                      cap_data;
    logic                            dirty_clr;

    assign s_tready = 1'b1;  // capture never stalls

    adxl_host_port i_host_port (
        .CLK         (CLK),
        .RESETN      (RESETN),
        .host_wr     (host_wr),
        .host_waddr  (host_waddr),
        .host_wdata  (host_wdata),
        .host_wstrb  (host_wstrb),
        .host_rd     (host_rd),
        .host_raddr  (host_raddr),
        .word_data   (word_data),
        .word_we     (word_we),
        .wr_data     (wr_data),
        .wr_strb     (wr_strb),
        .host_rdata  (host_rdata),
        .host_rvalid (host_rvalid)
    );

    for (genvar i = 0; i < NUM_WORDS; i++) begin : g_word
        adxl_reg_word #(
            .WORD_INDEX (i),
            .LANE_MASK  (WRITE_MASK[i])
        ) i_word (
            .CLK       (CLK),
            .RESETN    (RESETN),
            .we        (word_we[i]),
            .wr_data   (wr_data),
            .wr_strb   (wr_strb),
            .seq_addr  (seq_addr),
            .cap_we    (cap_we),
            .cap_data  (cap_data),
            .dirty_clr (dirty_clr),
            .data      (word_data[i*WORD_W +: WORD_W]),
            .dirty     (dirty[i*BYTE_LANES +: BYTE_LANES])
        );
    end

    adxl_sequencer i_sequencer (
        .CLK          (CLK),
        .RESETN       (RESETN),
        .enable       (enable),
        .req_interval (req_interval),
        .word_data    (word_data),
        .dirty        (dirty),
        .s_tdata      (s_tdata),
        .s_tvalid     (s_tvalid),
        .s_tlast      (s_tlast),
        .m_tready     (m_tready),
        .m_tdata      (m_tdata),
        .m_tuser      (m_tuser),
        .m_tlast      (m_tlast),
        .m_tvalid     (m_tvalid),
        .seq_addr     (seq_addr),
        .cap_we       (cap_we),
        .cap_data     (cap_data),
        .dirty_clr    (dirty_clr)
    );

endmodule

// ==== adxl_ctrl_props.sv ====
`timescale 1ns/1ps

module adxl_ctrl_props (
    input logic       CLK,
    input logic       RESETN,
    input logic [7:0] m_tdata,
    input logic [7:0] m_tuser,
    input logic       m_tlast,
    input logic       m_tvalid,
    input logic       m_tready,
    input logic       host_rd,
    input logic       host_rvalid
);

    int fail_count = 0;  // polled by the testbench

    // stalled byte held until taken
    a_stream_hold: assert property (@(posedge CLK) disable iff (!RESETN)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tuser)
            && $stable(m_tlast))
    else begin
        fail_count++;
        $error("command stream changed while stalled");
    end

    a_quiet_in_reset: assert property (@(posedge CLK) !RESETN |=> !m_tvalid)
    else begin
        fail_count++;
        $error("m_tvalid high after a reset edge");
    end

    a_read_return: assert property (@(posedge CLK) disable iff (!RESETN)
        host_rd |=> host_rvalid)
    else begin
        fail_count++;
        $error("host_rvalid missing one cycle after host_rd");
    end

    a_read_no_extra: assert property (@(posedge CLK) disable iff (!RESETN)
        host_rvalid |-> $past(host_rd))
    else begin
        fail_count++;
        $error("host_rvalid without a read one cycle earlier");
    end

endmodule

bind adxl_ctrl adxl_ctrl_props i_props (.*);

// ==== tb_adxl_ctrl.sv ====
`timescale 1ns/1ps

module tb_adxl_ctrl import adxl_pkg::*; ();

    localparam logic [7:0] REG_WRITE_CMD = 8'h02;
    localparam logic [7:0] PTR_CMD       = 8'h01;
    localparam logic [7:0] PTR_VALUE     = 8'h00;
    localparam logic [7:0] LAST_REG      = 8'h39;
    localparam logic [7:0] USER_WR       = {7'h53, 1'b0};
    localparam logic [7:0] USER_RD       = {7'h53, 1'b1};

    localparam int RESET_CYCLES   = 16;
    localparam int WRITE_ROUNDS   = 2;
    localparam int CAP_BYTES      = LAST_REG + 1;
    localparam int QUIET_CYCLES   = 200;
    localparam int READ_INTERVAL  = 20;
    localparam int MAX_FRAMES     = CAP_BYTES + 2;  // one per swept byte at most plus the read
    localparam int BYTE_BUDGET    = 16;             // cycles per byte under random ready
    localparam int HOST_OPS       = 2 * WRITE_ROUNDS * NUM_WORDS + 3 * NUM_WORDS;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 4 * HOST_OPS + 2 * CAP_BYTES
                                  + 3 * MAX_FRAMES * BYTE_BUDGET + CAP_BYTES
                                  + QUIET_CYCLES + READ_INTERVAL + 100;

    logic                  CLK;
    logic                  RESETN;
    logic                  host_wr;
    logic [WORD_IDX_W-1:0] host_waddr;
    logic [WORD_W-1:0]     host_wdata;
    logic [BYTE_LANES-1:0] host_wstrb;
    logic                  host_rd;
    logic [WORD_IDX_W-1:0] host_raddr;
    logic [WORD_W-1:0]     host_rdata;
    logic                  host_rvalid;
    logic                  enable;
    logic [31:0]           req_interval;
    logic [7:0]            m_tdata;
    logic [7:0]            m_tuser;
    logic                  m_tlast;
    logic                  m_tvalid;
    logic                  m_tready;
    logic [7:0]            s_tdata;
    logic                  s_tvalid;
    logic                  s_tlast;
    logic                  s_tready;

    int seed = 32'h00b2_9fd1;
    int cycle_count = 0;

    logic [WORD_W-1:0]     model_mem   [NUM_WORDS];
    logic [BYTE_LANES-1:0] model_dirty [NUM_WORDS];
    logic [WORD_W-1:0]     wdata_tab   [WRITE_ROUNDS*NUM_WORDS];
    logic [BYTE_LANES-1:0] wstrb_tab   [WRITE_ROUNDS*NUM_WORDS];
    logic [7:0]            cap_tab     [CAP_BYTES];
    logic [7:0]            exp_data[$];
    logic [7:0]            exp_user[$];
    logic                  exp_last[$];
    logic [WORD_W-1:0]     exp_rd[$];

    adxl_ctrl i_adxl_ctrl (
        .CLK          (CLK),
        .RESETN       (RESETN),
        .host_wr      (host_wr),
        .host_waddr   (host_waddr),
        .host_wdata   (host_wdata),
        .host_wstrb   (host_wstrb),
        .host_rd      (host_rd),
        .host_raddr   (host_raddr),
        .host_rdata   (host_rdata),
        .host_rvalid  (host_rvalid),
        .enable       (enable),
        .req_interval (req_interval),
        .m_tdata      (m_tdata),
        .m_tuser      (m_tuser),
        .m_tlast      (m_tlast),
        .m_tvalid     (m_tvalid),
        .m_tready     (m_tready),
        .s_tdata      (s_tdata),
        .s_tvalid     (s_tvalid),
        .s_tlast      (s_tlast),
        .s_tready     (s_tready)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [WORD_W-1:0] got,
                              input logic [WORD_W-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            abort_run("host read data differs from the mirror model");
        end
    endtask

    task automatic check_data(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got 0x%02h expected 0x%02h", $time, name, got, exp);
            abort_run("wrong byte on the command stream");
        end
    endtask

    task automatic check_user(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got 0x%02h expected 0x%02h", $time, name, got, exp);
            abort_run("wrong device address byte on the command stream");
        end
    endtask

    task automatic check_last(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
            abort_run("frame boundary in the wrong place");
        end
    endtask

    task automatic check_ready(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
            abort_run("capture stream not accepting bytes");
        end
    endtask

    // writable lanes of words 0x1c to 0x38
    function automatic logic [BYTE_LANES-1:0] lane_mask(input int w);
        case (w)
            7:       return 4'b1110;
            8:       return 4'b1111;
            9:       return 4'b1111;
            10:      return 4'b0111;
            11:      return 4'b1111;
            12:      return 4'b0010;
            14:      return 4'b0001;
            default: return 4'b0000;
        endcase
    endfunction

    function automatic logic [WORD_W-1:0] apply_write(input int w, input logic [WORD_W-1:0] old,
                                                      input logic [WORD_W-1:0] wdata,
                                                      input logic [BYTE_LANES-1:0] wstrb);
        logic [WORD_W-1:0]     res;
        logic [BYTE_LANES-1:0] lanes;
        res   = old;
        lanes = wstrb & lane_mask(w);
        for (int l = 0; l < BYTE_LANES; l++)
            if (lanes[l])
                res[l*8 +: 8] = wdata[l*8 +: 8];
        return res;
    endfunction

    task automatic push_byte(input logic [7:0] d, input logic [7:0] u, input logic l);
        exp_data.push_back(d);
        exp_user.push_back(u);
        exp_last.push_back(l);
    endtask

    // one frame per dirty byte in ascending address order
    task automatic queue_sweep_frames();
        for (int a = 0; a <= LAST_REG; a++) begin
            if (model_dirty[a/4][a%4]) begin
                push_byte(REG_WRITE_CMD, USER_WR, 1'b0);
                push_byte(a[7:0], USER_WR, 1'b0);
                push_byte(model_mem[a/4][(a%4)*8 +: 8], USER_WR, 1'b1);
                model_dirty[a/4][a%4] = 1'b0;
            end
        end
    endtask

    task automatic write_word(input int w, input logic [WORD_W-1:0] d,
                              input logic [BYTE_LANES-1:0] s);
        @(posedge CLK);
        host_wr        <= 1'b1;
        host_waddr     <= w[WORD_IDX_W-1:0];
        host_wdata     <= d;
        host_wstrb     <= s;
        model_mem[w]   = apply_write(w, model_mem[w], d, s);
        model_dirty[w] = model_dirty[w] | (s & lane_mask(w));
        @(posedge CLK);
        host_wr <= 1'b0;
    endtask

    task automatic read_word(input int w);
        @(posedge CLK);
        host_rd    <= 1'b1;
        host_raddr <= w[WORD_IDX_W-1:0];
        exp_rd.push_back(model_mem[w]);
        @(posedge CLK);
        host_rd <= 1'b0;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge CLK);
    endtask

    task automatic wait_stream_drained();
        while (exp_data.size() != 0)
            @(posedge CLK);
    endtask

    initial begin
        m_tready = 1'b0;
        forever begin
            @(posedge CLK);
            m_tready <= ($random(seed) & 32'h1) == 32'h1;
        end
    end

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
            abort_run($sformatf("timeout: run still busy after %0d cycles", cycle_count));
    end

    // sampled mid-cycle where valid and ready are stable
    always @(negedge CLK) begin
        if (i_adxl_ctrl.i_props.fail_count != 0) begin
            abort_run("a bound assertion on stream or read timing failed");
        end else if (RESETN) begin
            check_ready("s_tready", s_tready, 1'b1);
            if (m_tvalid && m_tready) begin
                if (exp_data.size() == 0) begin
                    abort_run("stream byte sent when no frame was expected");
                end else begin
                    check_data("m_tdata", m_tdata, exp_data.pop_front());
                    check_user("m_tuser", m_tuser, exp_user.pop_front());
                    check_last("m_tlast", m_tlast, exp_last.pop_front());
                end
            end
            if (host_rvalid) begin
                if (exp_rd.size() == 0)
                    abort_run("read data returned with no read pending");
                else
                    check_word("host_rdata", host_rdata, exp_rd.pop_front());
            end
        end
    end

    initial begin
        RESETN       = 1'b0;
        host_wr      = 1'b0;
        host_waddr   = '0;
        host_wdata   = '0;
        host_wstrb   = '0;
        host_rd      = 1'b0;
        host_raddr   = '0;
        enable       = 1'b0;
        req_interval = '1;  // no periodic read until lowered
        s_tdata      = '0;
        s_tvalid     = 1'b0;
        s_tlast      = 1'b0;
        for (int w = 0; w < NUM_WORDS; w++) begin
            model_mem[w]   = '0;
            model_dirty[w] = '0;
        end
        for (int i = 0; i < WRITE_ROUNDS * NUM_WORDS; i++) begin
            wdata_tab[i] = $random(seed);
            wstrb_tab[i] = 4'($random(seed));
        end
        for (int i = 0; i < CAP_BYTES; i++)
            cap_tab[i] = 8'($random(seed));

        repeat (RESET_CYCLES) @(posedge CLK);
        RESETN <= 1'b1;

        for (int w = 0; w < NUM_WORDS; w++)
            read_word(w);

        // nothing may leave on the stream while enable is low
        for (int r = 0; r < WRITE_ROUNDS; r++) begin
            for (int w = 0; w < NUM_WORDS; w++) begin
                write_word(w, wdata_tab[r*NUM_WORDS + w], wstrb_tab[r*NUM_WORDS + w]);
                read_word(w);
            end
        end

        queue_sweep_frames();
        @(posedge CLK);
        enable <= 1'b1;
        wait_stream_drained();
        wait_cycles(QUIET_CYCLES);  // a repeated frame would show up here
        for (int w = 0; w < NUM_WORDS; w++)
            read_word(w);

        push_byte(PTR_CMD, USER_WR, 1'b0);
        push_byte(PTR_VALUE, USER_WR, 1'b1);
        push_byte(LAST_REG, USER_RD, 1'b1);
        @(posedge CLK);
        req_interval <= READ_INTERVAL;
        wait_stream_drained();
        for (int i = 0; i < CAP_BYTES; i++) begin
            s_tvalid <= 1'b1;
            s_tdata  <= cap_tab[i];
            s_tlast  <= (i == CAP_BYTES - 1);
            model_mem[i/4][(i%4)*8 +: 8] = cap_tab[i];
            @(posedge CLK);
        end
        s_tvalid     <= 1'b0;
        s_tlast      <= 1'b0;
        enable       <= 1'b0;  // stop the next periodic read
        req_interval <= '1;
        wait_cycles(2);
        for (int w = 0; w < NUM_WORDS; w++)
            read_word(w);

        wait_cycles(4);
        if (exp_rd.size() != 0 || exp_data.size() != 0) begin
            abort_run("expected responses still outstanding at the end");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// ==== adxl_ctrl.f ====
adxl_pkg.sv
adxl_host_port.sv
adxl_reg_word.sv
adxl_sequencer.sv
adxl_ctrl.sv
adxl_ctrl_props.sv
tb_adxl_ctrl.sv
